// ==== gat_wh_top.f ====
gat_pkg.sv
bram.sv
memory_controller.sv
axi_lite_slave.sv
row_fetch.sv
wh_mac.sv
gat_wh_top.sv
gat_wh_props.sv
tb_gat_wh_top.sv

// ==== Makefile ====
# Verilator build and run of the GAT WH projection testbench

BIN := obj_dir/Vtb_gat_wh_top

.PHONY: all run clean

all: run

$(BIN): gat_wh_top.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	  --top-module tb_gat_wh_top -f gat_wh_top.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

// ==== tb_gat_wh_top.sv ====
/*
 * Testbench for the GAT WH projection
 * Loads random sparse H and weights over AXI4-Lite, runs the pipeline
 * and compares every WH lane with a software model of H x W
 */
`default_nettype none

module tb_gat_wh_top
  import gat_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_FEATURE_IN = 16;
  localparam int TOTAL_NODES    = 8;
  localparam int H_DEPTH        = 64;
  localparam int ACC_W          = 2 * DATA_WIDTH + $clog2(NUM_FEATURE_IN);
  localparam int EMPTY_NODE     = 3;
  localparam int TIMEOUT        = 1000;

  logic                      clk, rst_n;
  logic [AXI_ADDR_WIDTH-1:0] awaddr, araddr;
  logic [AXI_DATA_WIDTH-1:0] wdata, rdata;
  logic [AXI_STRB_WIDTH-1:0] wstrb;
  logic [1:0]                bresp, rresp;
  logic                      awvalid, awready, wvalid, wready, bvalid, bready;
  logic                      arvalid, arready, rvalid, rready;

  // Host copy of what was loaded
  int row_len [TOTAL_NODES];
  int h_val [$];
  int h_col [$];
  int weight [NUM_FEATURE_IN][NUM_LANES];

  // Read results waiting for the compare process
  string       name_q [$];
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];

  gat_wh_top #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN),
    .TOTAL_NODES    (TOTAL_NODES),
    .H_DEPTH        (H_DEPTH)
  ) uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ============================================================
  // Error handling and the model
  // ============================================================
  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic wait_timeout(input string what);
    $display("Timeout waiting for %s", what);
    stop_on_error();
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  function automatic void expect_value(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endfunction

  // Sum over the node's entries of value times weight(column, lane)
  function automatic logic [31:0] ref_lane(input int node, input int lane);
    int                      base;
    logic signed [ACC_W-1:0] acc;
    base = 0;
    acc  = '0;
    for (int n = 0; n < node; n++) begin
      base += row_len[n];
    end
    for (int i = 0; i < row_len[node]; i++) begin
      acc += ACC_W'(h_val[base + i] * weight[h_col[base + i]][lane]);
    end
    return 32'(acc);
  endfunction

  initial begin
    forever begin
      @(posedge clk);
      while (got_q.size() > 0) begin
        check(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
      end
    end
  end

  // ============================================================
  // AXI4-Lite host, called 1 ns after a rising edge
  // ============================================================
  // Holds bready low for stall cycles once bvalid is up
  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           input int stall, output logic [1:0] resp);
    int t;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (stall == 0);
    t = 0;
    @(negedge clk);
    while (!(awready && wready)) begin
      if (++t > TIMEOUT) wait_timeout("the write handshake");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    t = 0;
    @(negedge clk);
    while (!bvalid) begin
      if (++t > TIMEOUT) wait_timeout("the write response");
      @(negedge clk);
    end
    repeat (stall) @(negedge clk);
    resp = bresp;
    @(posedge clk);
    #1;
    if (!bready) begin
      bready = 1'b1;
      @(posedge clk);
      #1;
    end
  endtask

  // Holds rready low for stall cycles once rvalid is up
  task automatic axi_read(input logic [11:0] addr, input int stall,
                          output logic [31:0] data, output logic [1:0] resp);
    int t;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = (stall == 0);
    t = 0;
    @(negedge clk);
    while (!arready) begin
      if (++t > TIMEOUT) wait_timeout("the read handshake");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    t = 0;
    @(negedge clk);
    while (!rvalid) begin
      if (++t > TIMEOUT) wait_timeout("the read data");
      @(negedge clk);
    end
    repeat (stall) @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    if (!rready) begin
      rready = 1'b1;
      @(posedge clk);
      #1;
    end
  endtask

  // ============================================================
  // Test steps
  // ============================================================
  task automatic load_graph();
    logic [1:0] resp;
    h_val.delete();
    h_col.delete();
    for (int n = 0; n < TOTAL_NODES; n++) begin
      row_len[n] = (n == EMPTY_NODE) ? 0 : int'($urandom_range(6, 1));
      axi_write(BASE_NODE_INFO + 12'(4 * n), 32'(row_len[n]), 0, resp);
      expect_value("bresp node info", 32'(resp), 32'(RESP_OKAY));
      for (int i = 0; i < row_len[n]; i++) begin
        h_val.push_back(int'($urandom_range(255)) - 128);
        h_col.push_back(int'($urandom_range(NUM_FEATURE_IN - 1)));
      end
    end
    foreach (h_val[i]) begin
      axi_write(BASE_H_DATA + 12'(4 * i), {h_col[i][23:0], h_val[i][7:0]}, 0, resp);
      expect_value("bresp h data", 32'(resp), 32'(RESP_OKAY));
    end
  endtask

  task automatic load_weights(input int stall_max);
    logic [1:0]  resp;
    logic [31:0] word;
    for (int f = 0; f < NUM_FEATURE_IN; f++) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        weight[f][k] = int'($urandom_range(255)) - 128;
        word[k*8 +: 8] = weight[f][k][7:0];
      end
      axi_write(BASE_WEIGHT + 12'(4 * f), word, int'($urandom_range(stall_max)), resp);
      expect_value("bresp weight", 32'(resp), 32'(RESP_OKAY));
    end
  endtask

  // Optional weight write while busy must be refused
  task automatic run_layer(input bit poke_weight);
    logic [1:0]  resp;
    logic [31:0] status;
    int          polls;
    axi_write(ADDR_CTRL, 32'h1, 0, resp);
    expect_value("bresp start", 32'(resp), 32'(RESP_OKAY));
    axi_read(ADDR_STATUS, 0, status, resp);
    expect_value("status after start", status, 32'h1);
    if (poke_weight) begin
      // Weight row read by the last node, late in the run
      axi_write(BASE_WEIGHT + 12'(4 * h_col[$]), 32'h7f7f_7f7f, 0, resp);
      expect_value("bresp weight while busy", 32'(resp), 32'(RESP_SLVERR));
    end
    polls = 0;
    do begin
      if (++polls > TIMEOUT) wait_timeout("done in STATUS");
      axi_read(ADDR_STATUS, 0, status, resp);
    end while (!status[1]);
    expect_value("status at done", status, 32'h2);
  endtask

  task automatic check_results(input int stall_max);
    logic [31:0] data;
    logic [1:0]  resp;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        axi_read(BASE_WH + 12'(16 * n + 4 * k), int'($urandom_range(stall_max)),
                 data, resp);
        expect_value($sformatf("wh[%0d][%0d]", n, k), data, ref_lane(n, k));
        expect_value("rresp wh", 32'(resp), 32'(RESP_OKAY));
      end
    end
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    int          t;
    void'($urandom(2047));
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '1;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    axi_read(ADDR_STATUS, 0, data, resp);
    expect_value("status after reset", data, 32'h0);
    expect_value("rresp status", 32'(resp), 32'(RESP_OKAY));

    load_graph();
    load_weights(0);
    run_layer(1'b1);
    check_results(0);

    // Unmapped address below the node info region
    axi_write(12'h0f0, 32'hdead_beef, 0, resp);
    expect_value("bresp unmapped", 32'(resp), 32'(RESP_SLVERR));
    axi_read(12'h0f0, 0, data, resp);
    expect_value("rdata unmapped", data, 32'h0);
    expect_value("rresp unmapped", 32'(resp), 32'(RESP_SLVERR));

    // Same H, new weights, both response channels stalled
    load_weights(3);
    run_layer(1'b0);
    check_results(4);

    t = 0;
    while (got_q.size() > 0) begin
      if (++t > TIMEOUT) wait_timeout("the compare process");
      @(posedge clk);
    end
    if (uut.u_axi_lite_slave.u_props.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Protocol assertion failed during the run");
      stop_on_error();
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== gat_wh_props.sv ====
/*
 * AXI4-Lite response channel checks, bound into the slave
 * Responses hold until taken and stay stable while stalled,
 * run status is idle out of reset
 */
`default_nettype none

module gat_wh_props
  import gat_pkg::*;
(
  input logic                      clk,
  input logic                      rst_n,
  input logic                      bvalid,
  input logic                      bready,
  input logic [1:0]                bresp,
  input logic                      rvalid,
  input logic                      rready,
  input logic [AXI_DATA_WIDTH-1:0] rdata,
  input logic [1:0]                rresp,
  input logic                      busy,
  input logic                      done
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions, seen by the testbench at the end of the run
  int unsigned fail_count = 0;

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $error("bvalid dropped or bresp changed before bready");
      fail_count++;
    end

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $error("rvalid dropped or read response changed before rready");
      fail_count++;
    end

  // First cycle out of reset
  a_idle: assert property (@(posedge clk) $rose(rst_n) |-> !busy && !done)
    else begin
      $error("busy or done set right after reset");
      fail_count++;
    end

endmodule

bind axi_lite_slave gat_wh_props u_props (
  .clk    (clk),
  .rst_n  (rst_n),
  .bvalid (bvalid),
  .bready (bready),
  .bresp  (bresp),
  .rvalid (rvalid),
  .rready (rready),
  .rdata  (rdata),
  .rresp  (rresp),
  .busy   (busy),
  .done   (done)
);

`default_nettype wire

// ==== gat_wh_top.sv ====
/*
 * GAT WH projection top level
 * AXI4-Lite front end, on-chip memories and the row fetch and
 * multiply-accumulate pipeline computing WH = H x W
 */
`default_nettype none

module gat_wh_top
  import gat_pkg::*;
#(
  parameter int NUM_FEATURE_IN = 16,
  parameter int TOTAL_NODES    = 8,
  parameter int H_DEPTH        = 64,
  localparam int NODE_AW = $clog2(TOTAL_NODES),
  localparam int FEAT_AW = $clog2(NUM_FEATURE_IN),
  localparam int H_AW    = $clog2(H_DEPTH),
  localparam int LEN_W   = $clog2(H_DEPTH + 1),
  localparam int H_W     = DATA_WIDTH + FEAT_AW,
  localparam int WH_W    = NUM_LANES * (2 * DATA_WIDTH + FEAT_AW)
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [AXI_DATA_WIDTH-1:0] wdata,
  input  logic [AXI_STRB_WIDTH-1:0] wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [AXI_ADDR_WIDTH-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [AXI_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready
);

  // Host side
  logic                      node_info_we, h_data_we, wgt_we;
  logic [NODE_AW-1:0]        node_info_addr, wh_rd_addr;
  logic [H_REGION_AW-1:0]    h_data_addr;
  logic [WGT_REGION_AW-1:0]  wgt_addr;
  logic [AXI_DATA_WIDTH-1:0] host_din;
  logic [WH_W-1:0]           wh_dout;
  logic                      start, row_done;
  logic [NODE_AW-1:0]        done_node;

  // Pipeline side
  logic [NODE_AW-1:0]        node_info_rd_addr, item_node, wh_wr_addr;
  logic [LEN_W-1:0]          node_info_dout;
  logic [H_AW-1:0]           h_data_rd_addr;
  logic [H_W-1:0]            h_data_dout;
  logic [FEAT_AW-1:0]        wgt_rd_addr;
  logic [WGT_ROW_WIDTH-1:0]  wgt_dout;
  logic                      item_valid, item_last, item_empty, wh_we;
  logic [WH_W-1:0]           wh_din;

  axi_lite_slave #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN),
    .TOTAL_NODES    (TOTAL_NODES)
  ) u_axi_lite_slave (.*);

  memory_controller #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN),
    .TOTAL_NODES    (TOTAL_NODES),
    .H_DEPTH        (H_DEPTH)
  ) u_memory_controller (.*);

  row_fetch #(
    .TOTAL_NODES (TOTAL_NODES),
    .H_DEPTH     (H_DEPTH)
  ) u_row_fetch (.*);

  wh_mac #(
    .NUM_FEATURE_IN (NUM_FEATURE_IN),
    .TOTAL_NODES    (TOTAL_NODES)
  ) u_wh_mac (.*);

endmodule

`default_nettype wire

// ==== wh_mac.sv ====
/*
 * WH multiply-accumulate, second and third pipeline stages
 * Stage 1 takes the H word and fetches the weight row by column,
 * stage 2 multiplies into four signed lanes and writes the WH row
 * on the last item of a node
 */
`default_nettype none

module wh_mac
  import gat_pkg::*;
#(
  parameter int NUM_FEATURE_IN = 16,
  parameter int TOTAL_NODES    = 8,
  localparam int NODE_AW = $clog2(TOTAL_NODES),
  localparam int FEAT_AW = $clog2(NUM_FEATURE_IN),
  localparam int H_W     = DATA_WIDTH + FEAT_AW,
  localparam int ACC_W   = 2 * DATA_WIDTH + FEAT_AW,
  localparam int WH_W    = NUM_LANES * ACC_W
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     item_valid,
  input  logic [NODE_AW-1:0]       item_node,
  input  logic                     item_last,
  input  logic                     item_empty,
  input  logic [H_W-1:0]           h_data_dout,
  output logic [FEAT_AW-1:0]       wgt_rd_addr,
  input  logic [WGT_ROW_WIDTH-1:0] wgt_dout,
  output logic                     wh_we,
  output logic [NODE_AW-1:0]       wh_wr_addr,
  output logic [WH_W-1:0]          wh_din,
  output logic                     row_done,
  output logic [NODE_AW-1:0]       done_node
);

  logic                         s1_valid, s1_last, s1_empty;
  logic [NODE_AW-1:0]           s1_node;
  logic                         s2_valid, s2_last, s2_empty;
  logic [NODE_AW-1:0]           s2_node;
  logic signed [DATA_WIDTH-1:0] s2_val;

  // Tags follow the H and weight memory latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= item_valid;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_node  <= item_node;
    s1_last  <= item_last;
    s1_empty <= item_empty;
    s2_node  <= s1_node;
    s2_last  <= s1_last;
    s2_empty <= s1_empty;
    s2_val   <= h_data_dout[DATA_WIDTH-1:0];
  end

  // Column index selects the weight row
  assign wgt_rd_addr = h_data_dout[DATA_WIDTH +: FEAT_AW];

  // ============================================================
  // Lane datapath
  // ============================================================
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    logic signed [DATA_WIDTH-1:0]   wgt;
    logic signed [2*DATA_WIDTH-1:0] prod;
    logic signed [ACC_W-1:0]        acc, sum;

    assign wgt  = wgt_dout[k*DATA_WIDTH +: DATA_WIDTH];
    assign prod = s2_val * wgt;
    assign sum  = acc + ACC_W'(prod);
    assign wh_din[k*ACC_W +: ACC_W] = s2_empty ? '0 : sum;

    // Cleared on the last item, ready for the next node
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        acc <= '0;
      end else if (s2_valid && !s2_empty) begin
        acc <= s2_last ? '0 : sum;
      end
    end
  end

  assign wh_we      = s2_valid && s2_last;
  assign wh_wr_addr = s2_node;
  assign row_done   = wh_we;
  assign done_node  = s2_node;

endmodule

`default_nettype wire

// ==== row_fetch.sv ====
/*
 * Row fetch, first pipeline stage
 * Walks the node info memory node by node and issues one sparse H
 * address per cycle, tagged with node index, last and empty flags
 */
`default_nettype none

module row_fetch #(
  parameter int TOTAL_NODES = 8,
  parameter int H_DEPTH     = 64,
  localparam int NODE_AW = $clog2(TOTAL_NODES),
  localparam int H_AW    = $clog2(H_DEPTH),
  localparam int LEN_W   = $clog2(H_DEPTH + 1)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  output logic [NODE_AW-1:0] node_info_rd_addr,
  input  logic [LEN_W-1:0]   node_info_dout,
  output logic [H_AW-1:0]    h_data_rd_addr,
  output logic               item_valid,
  output logic [NODE_AW-1:0] item_node,
  output logic               item_last,
  output logic               item_empty
);

  localparam logic [1:0] S_IDLE = 2'd0, S_ADDR = 2'd1, S_DATA = 2'd2, S_EMIT = 2'd3;

  logic [1:0]         state;
  logic [NODE_AW-1:0] node;
  logic [H_AW-1:0]    row_base;
  logic [LEN_W-1:0]   cnt;

  // Node info stays on the memory output while the node is emitted
  assign node_info_rd_addr = node;
  assign h_data_rd_addr    = row_base + H_AW'(cnt);
  assign item_valid        = state == S_EMIT;
  assign item_node         = node;
  // Empty row still emits a single item so its WH row is written
  assign item_empty        = node_info_dout == '0;
  assign item_last         = item_empty || cnt == node_info_dout - LEN_W'(1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      node     <= '0;
      row_base <= '0;
      cnt      <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            node     <= '0;
            row_base <= '0;
            state    <= S_ADDR;
          end
        end
        S_ADDR: begin
          cnt   <= '0;
          state <= S_DATA;
        end
        S_DATA: state <= S_EMIT;
        default: begin
          if (item_last) begin
            // Rows are stored back to back
            row_base <= row_base + H_AW'(node_info_dout);
            cnt      <= '0;
            if (node == NODE_AW'(TOTAL_NODES - 1)) begin
              state <= S_IDLE;
            end else begin
              node  <= node + 1'b1;
              state <= S_ADDR;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== axi_lite_slave.sv ====
/*
 * AXI4-Lite front end
 * Decodes the address map into memory writes, the start control and
 * the status register, and returns WH lanes sign-extended to 32 bits.
 * Holds busy and done for the run
 */
`default_nettype none

module axi_lite_slave
  import gat_pkg::*;
#(
  parameter int NUM_FEATURE_IN = 16,
  parameter int TOTAL_NODES    = 8,
  localparam int NODE_AW = $clog2(TOTAL_NODES),
  localparam int LANE_W  = $clog2(NUM_LANES),
  localparam int ACC_W   = 2 * DATA_WIDTH + $clog2(NUM_FEATURE_IN),
  localparam int WH_W    = NUM_LANES * ACC_W
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [AXI_DATA_WIDTH-1:0] wdata,
  input  logic [AXI_STRB_WIDTH-1:0] wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [AXI_ADDR_WIDTH-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [AXI_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  output logic                      node_info_we,
  output logic [NODE_AW-1:0]        node_info_addr,
  output logic                      h_data_we,
  output logic [H_REGION_AW-1:0]    h_data_addr,
  output logic                      wgt_we,
  output logic [WGT_REGION_AW-1:0]  wgt_addr,
  output logic [AXI_DATA_WIDTH-1:0] host_din,
  output logic [NODE_AW-1:0]        wh_rd_addr,
  input  logic [WH_W-1:0]           wh_dout,
  output logic                      start,
  input  logic                      row_done,
  input  logic [NODE_AW-1:0]        done_node
);

  localparam logic [2:0] R_NONE = 3'd0, R_CTRL = 3'd1, R_STATUS = 3'd2, R_NI = 3'd3;
  localparam logic [2:0] R_WGT = 3'd4, R_H = 3'd5, R_WH = 3'd6;

  logic                     busy, done;
  logic [2:0]               wr_region, rd_region;
  logic                     mem_wr, wr_ok, start_req, ar_hs;
  logic [H_REGION_AW-1:0]   wr_word;
  logic                     rd_pend, rd_wh, rd_status, rd_err;
  logic [LANE_W-1:0]        rd_lane;
  logic signed [ACC_W-1:0]  wh_lane;

  function automatic logic [2:0] decode(input logic [AXI_ADDR_WIDTH-1:0] a);
    if (a == ADDR_CTRL) return R_CTRL;
    if (a == ADDR_STATUS) return R_STATUS;
    if (a >= BASE_NODE_INFO && a < BASE_NODE_INFO + 4 * TOTAL_NODES) return R_NI;
    if (a >= BASE_WEIGHT && a < BASE_WEIGHT + 4 * NUM_FEATURE_IN) return R_WGT;
    if (a >= BASE_H_DATA && a < BASE_WH) return R_H;
    if (a >= BASE_WH && a < BASE_WH + 4 * NUM_LANES * TOTAL_NODES) return R_WH;
    return R_NONE;
  endfunction

  // ============================================================
  // Write channel
  // ============================================================
  // Address and data taken together, one response at a time
  assign awready   = awvalid && wvalid && !bvalid;
  assign wready    = awready;
  assign wr_region = decode(awaddr);
  // Input memories are locked while a run is in progress
  assign mem_wr    = (wr_region inside {R_NI, R_WGT, R_H}) && !busy && (&wstrb);
  assign wr_ok     = mem_wr || wr_region == R_CTRL || wr_region == R_STATUS;
  assign start_req = awready && wr_region == R_CTRL && wstrb[0] && wdata[0] && !busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid       <= 1'b0;
      bresp        <= RESP_OKAY;
      node_info_we <= 1'b0;
      wgt_we       <= 1'b0;
      h_data_we    <= 1'b0;
      start        <= 1'b0;
    end else begin
      node_info_we <= awready && mem_wr && wr_region == R_NI;
      wgt_we       <= awready && mem_wr && wr_region == R_WGT;
      h_data_we    <= awready && mem_wr && wr_region == R_H;
      start        <= start_req;
      if (awready) begin
        bvalid <= 1'b1;
        bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awready) begin
      wr_word  <= awaddr[H_REGION_AW+1:2];
      host_din <= wdata;
    end
  end

  // Regions are aligned, so the low word bits index every memory
  assign node_info_addr = wr_word[NODE_AW-1:0];
  assign wgt_addr       = wr_word[WGT_REGION_AW-1:0];
  assign h_data_addr    = wr_word;

  // ============================================================
  // Run control
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (start_req) begin
      busy <= 1'b1;
      done <= 1'b0;
    end else if (busy && row_done && done_node == NODE_AW'(TOTAL_NODES - 1)) begin
      busy <= 1'b0;
      done <= 1'b1;
    end
  end

  // ============================================================
  // Read channel
  // ============================================================
  assign arready    = !rd_pend && !rvalid;
  assign ar_hs      = arvalid && arready;
  assign rd_region  = decode(araddr);
  // WH row address goes straight to the memory, data arrives in rd_pend
  assign wh_rd_addr = araddr[2+LANE_W +: NODE_AW];
  assign wh_lane    = wh_dout[rd_lane*ACC_W +: ACC_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      rd_pend <= ar_hs;
      if (rd_pend) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_lane   <= araddr[2 +: LANE_W];
      rd_wh     <= rd_region == R_WH;
      rd_status <= rd_region == R_STATUS;
      rd_err    <= rd_region inside {R_NONE, R_NI, R_WGT, R_H};
    end
    if (rd_pend) begin
      rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
      if (rd_wh) begin
        rdata <= AXI_DATA_WIDTH'(wh_lane);
      end else if (rd_status) begin
        rdata <= AXI_DATA_WIDTH'({done, busy});
      end else begin
        rdata <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== memory_controller.sv ====
/*
 * Memory controller
 * Holds the sparse H, node info, weight and WH memories. Host writes
 * come in as bus words and are narrowed to each memory's format, the
 * pipeline owns the read ports and the WH write port
 */
`default_nettype none

module memory_controller
  import gat_pkg::*;
#(
  parameter int NUM_FEATURE_IN = 16,
  parameter int TOTAL_NODES    = 8,
  parameter int H_DEPTH        = 64,
  localparam int NODE_AW = $clog2(TOTAL_NODES),
  localparam int FEAT_AW = $clog2(NUM_FEATURE_IN),
  localparam int H_AW    = $clog2(H_DEPTH),
  localparam int LEN_W   = $clog2(H_DEPTH + 1),
  localparam int H_W     = DATA_WIDTH + FEAT_AW,
  localparam int ACC_W   = 2 * DATA_WIDTH + FEAT_AW,
  localparam int WH_W    = NUM_LANES * ACC_W
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // Host writes
  input  logic                      node_info_we,
  input  logic [NODE_AW-1:0]        node_info_addr,
  input  logic                      h_data_we,
  input  logic [H_REGION_AW-1:0]    h_data_addr,
  input  logic                      wgt_we,
  input  logic [WGT_REGION_AW-1:0]  wgt_addr,
  input  logic [AXI_DATA_WIDTH-1:0] host_din,
  // Pipeline reads
  input  logic [NODE_AW-1:0]        node_info_rd_addr,
  input  logic [H_AW-1:0]           h_data_rd_addr,
  input  logic [FEAT_AW-1:0]        wgt_rd_addr,
  output logic [LEN_W-1:0]          node_info_dout,
  output logic [H_W-1:0]            h_data_dout,
  output logic [WGT_ROW_WIDTH-1:0]  wgt_dout,
  // WH results
  input  logic                      wh_we,
  input  logic [NODE_AW-1:0]        wh_wr_addr,
  input  logic [WH_W-1:0]           wh_din,
  input  logic [NODE_AW-1:0]        wh_rd_addr,
  output logic [WH_W-1:0]           wh_dout
);

  // ============================================================
  // Input memories
  // ============================================================
  bram #(.DATA_WIDTH(LEN_W), .DEPTH(TOTAL_NODES)) u_node_info_bram (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (host_din[LEN_W-1:0]),
    .addra (node_info_addr),
    .wea   (node_info_we),
    .addrb (node_info_rd_addr),
    .dout  (node_info_dout)
  );

  // Value in the low byte, column index above it
  bram #(.DATA_WIDTH(H_W), .DEPTH(H_DEPTH)) u_h_data_bram (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (host_din[H_W-1:0]),
    .addra (h_data_addr[H_AW-1:0]),
    .wea   (h_data_we),
    .addrb (h_data_rd_addr),
    .dout  (h_data_dout)
  );

  bram #(.DATA_WIDTH(WGT_ROW_WIDTH), .DEPTH(NUM_FEATURE_IN)) u_wgt_bram (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (host_din[WGT_ROW_WIDTH-1:0]),
    .addra (wgt_addr[FEAT_AW-1:0]),
    .wea   (wgt_we),
    .addrb (wgt_rd_addr),
    .dout  (wgt_dout)
  );

  // ============================================================
  // WH rows, four accumulator lanes per node
  // ============================================================
  bram #(.DATA_WIDTH(WH_W), .DEPTH(TOTAL_NODES)) u_wh_bram (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (wh_din),
    .addra (wh_wr_addr),
    .wea   (wh_we),
    .addrb (wh_rd_addr),
    .dout  (wh_dout)
  );

endmodule

`default_nettype wire

// ==== bram.sv ====
/*
 * Simple dual-port block RAM
 * One write port and one read port with a registered output,
 * one cycle from read address to data
 */
`default_nettype none

module bram #(
  parameter int DATA_WIDTH = 8,
  parameter int DEPTH      = 16,
  localparam int ADDR_W    = $clog2(DEPTH)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic [ADDR_W-1:0]     addra,
  input  logic                  wea,
  input  logic [ADDR_W-1:0]     addrb,
  output logic [DATA_WIDTH-1:0] dout
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wea) begin
      mem[addra] <= din;
    end
  end

  // Read every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dout <= '0;
    end else begin
      dout <= mem[addrb];
    end
  end

endmodule

`default_nettype wire

// ==== gat_pkg.sv ====
/*
 * GAT WH projection, shared definitions
 * Data format, AXI4-Lite address map and response codes used by the
 * host front end, the memories and the WH pipeline
 */
`default_nettype none

package gat_pkg;

  // ============================================================
  // Data format
  // ============================================================
  localparam int DATA_WIDTH    = 8;
  localparam int NUM_LANES     = 4;
  // One weight row fills one bus word
  localparam int WGT_ROW_WIDTH = NUM_LANES * DATA_WIDTH;

  // ============================================================
  // AXI4-Lite
  // ============================================================
  localparam int AXI_ADDR_WIDTH = 12;
  localparam int AXI_DATA_WIDTH = 32;
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_CTRL      = 12'h000;
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_STATUS    = 12'h004;
  localparam logic [AXI_ADDR_WIDTH-1:0] BASE_NODE_INFO = 12'h100;
  localparam logic [AXI_ADDR_WIDTH-1:0] BASE_WEIGHT    = 12'h200;
  localparam logic [AXI_ADDR_WIDTH-1:0] BASE_H_DATA    = 12'h400;
  localparam logic [AXI_ADDR_WIDTH-1:0] BASE_WH        = 12'h800;

  // Word offset widths of the weight and H regions
  localparam int WGT_REGION_AW = $clog2(BASE_H_DATA - BASE_WEIGHT) - 2;
  localparam int H_REGION_AW   = $clog2(BASE_WH - BASE_H_DATA) - 2;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
